// ==== wisc16.f ====
design/wiscPkg.sv
design/controlDecoder.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/wiscCore.sv
tests/wiscCoreTb.sv

// ==== Makefile ====
TOP = wiscCoreTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f wisc16.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/wiscCoreTb.sv ====
`timescale 1ns/1ps

module wiscCoreTb import wiscPkg::*; #(
   parameter logic [DataWidth-1:0] ResetPc = 16'h0040   // Off zero to catch a bad reset
);

   localparam logic [15:0] NopWord = {OpNop, 11'd0};
   localparam int AluOps     = 40;
   localparam int MemPairs   = 8;
   localparam int NumInstr   = 8 + (14 + AluOps) + (3 * MemPairs + 2) + 28 + 6 + 14;
   localparam int WatchdogNs = (NumInstr + 20) * 10;    // One cycle per issue plus margin

   logic                 clk = 1'b0;
   logic                 rstN;
   instrU                instr;
   logic                 instrValid;
   logic [DataWidth-1:0] memRdata;
   memReqT               memReq;
   wbT                   wb;
   logic [DataWidth-1:0] pc;
   logic                 halted;
   logic                 err;

   logic [DataWidth-1:0] mem [0:255];                   // Data memory stub
   logic [DataWidth-1:0] mMem [0:255];                  // Model view of memory
   logic [DataWidth-1:0] mRegs [0:7];
   logic [DataWidth-1:0] mPc;
   logic                 mHalted;
   wbT                   expWb;                         // Expected for the cycle in flight
   memReqT               expReq;
   logic                 expErr;
   logic                 expHalt;
   logic                 expEn;
   logic [DataWidth-1:0] expNextPc;
   integer               seed = 23721;
   int                   errCount;
   int                   errAtStart;
   int                   testsPassed;
   int                   testsFailed;

   wiscCore #(
      .ResetPc (ResetPc)
   ) i_dut (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .instrValid (instrValid),
      .memRdata   (memRdata),
      .memReq     (memReq),
      .wb         (wb),
      .pc         (pc),
      .halted     (halted),
      .err        (err)
   );

   always #5 clk = ~clk;

   assign memRdata = mem[memReq.addr[7:0]];             // Answers in the same cycle
   always @(posedge clk) begin
      if (memReq.wrEn) begin
         mem[memReq.addr[7:0]] = memReq.wdata;
      end
   end

   task automatic mismatch(input string msg);
      errCount++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   aPc: assert property (@(posedge clk) disable iff (!rstN) pc == mPc)
      else mismatch($sformatf("pc %h, expected %h", $sampled(pc), mPc));
   aHalted: assert property (@(posedge clk) disable iff (!rstN) halted == mHalted)
      else mismatch($sformatf("halted %b, expected %b", $sampled(halted), mHalted));
   aErr: assert property (@(posedge clk) disable iff (!rstN) err == expErr)
      else mismatch($sformatf("err %b, expected %b", $sampled(err), expErr));
   aWbEn: assert property (@(posedge clk) disable iff (!rstN) wb.en == expWb.en)
      else mismatch($sformatf("wb.en %b, expected %b", $sampled(wb.en), expWb.en));
   aWbVal: assert property (@(posedge clk) disable iff (!rstN)
         expWb.en |-> (wb.regIdx == expWb.regIdx && wb.data == expWb.data))
      else mismatch($sformatf("wb r%0d=%h, expected r%0d=%h", $sampled(wb.regIdx),
                              $sampled(wb.data), expWb.regIdx, expWb.data));
   aStrobes: assert property (@(posedge clk) disable iff (!rstN)
         memReq.rdEn == expReq.rdEn && memReq.wrEn == expReq.wrEn)
      else mismatch("memory strobes differ from model");
   aAddr: assert property (@(posedge clk) disable iff (!rstN)
         (expReq.rdEn || expReq.wrEn) |-> memReq.addr == expReq.addr)
      else mismatch($sformatf("mem addr %h, expected %h", $sampled(memReq.addr), expReq.addr));
   aWdata: assert property (@(posedge clk) disable iff (!rstN)
         expReq.wrEn |-> memReq.wdata == expReq.wdata)
      else mismatch($sformatf("mem wdata %h, expected %h", $sampled(memReq.wdata),
                              expReq.wdata));
   aIdle: assert property (@(posedge clk) disable iff (!rstN)
         !instrValid |-> (!wb.en && !memReq.rdEn && !memReq.wrEn))
      else mismatch("write strobe active while instrValid low");

   task automatic setWrite(input logic [2:0] idx, input logic [DataWidth-1:0] data);
      expWb = '{en: 1'b1, regIdx: idx, data: data};
   endtask

   // ISA reference for one instruction against the model state
   task automatic predict(input instrU i, input logic valid);
      logic [DataWidth-1:0] a;
      logic [DataWidth-1:0] b;
      logic [DataWidth-1:0] s5;
      logic [DataWidth-1:0] z5;
      logic [DataWidth-1:0] addr;
      logic [7:0]           imm8;
      logic [10:0]          imm11;
      logic                 taken;
      a     = mRegs[i.rFmt.rs];
      b     = mRegs[i.rFmt.rt];
      s5    = {{11{i.iFmt.imm5[4]}}, i.iFmt.imm5};
      z5    = {11'd0, i.iFmt.imm5};
      imm8  = {i.iFmt.rd, i.iFmt.imm5};
      imm11 = {i.iFmt.rs, i.iFmt.rd, i.iFmt.imm5};
      addr  = a + s5;                                   // LD and ST effective address
      expEn     = valid && !mHalted;
      expWb     = '0;
      expReq    = '0;
      expErr    = 1'b0;
      expHalt   = 1'b0;
      expNextPc = mPc + 16'd2;
      case (i.rFmt.opcode)
         OpAlu: begin
            case (i.rFmt.func)
               2'd0:    setWrite(i.rFmt.rd, a + b);
               2'd1:    setWrite(i.rFmt.rd, b - a);     // Rt minus rs
               2'd2:    setWrite(i.rFmt.rd, a ^ b);
               default: setWrite(i.rFmt.rd, a & ~b);
            endcase
         end
         OpAddi:  setWrite(i.iFmt.rd, a + s5);
         OpSubi:  setWrite(i.iFmt.rd, s5 - a);
         OpXori:  setWrite(i.iFmt.rd, a ^ z5);            // Logical forms zero-extend
         OpAndni: setWrite(i.iFmt.rd, a & ~z5);
         OpLbi:   setWrite(i.iFmt.rs, {{8{imm8[7]}}, imm8});
         OpSlbi:  setWrite(i.iFmt.rs, (a << 8) | {8'd0, imm8});
         OpSt:    expReq = '{rdEn: 1'b0, wrEn: 1'b1, addr: addr, wdata: mRegs[i.iFmt.rd]};
         OpLd: begin
            expReq = '{rdEn: 1'b1, wrEn: 1'b0, addr: addr, wdata: 16'd0};
            setWrite(i.iFmt.rd, mMem[addr[7:0]]);
         end
         OpBeqz, OpBnez, OpBltz, OpBgez: begin
            case (i.rFmt.opcode)
               OpBeqz:  taken = (a == 16'd0);
               OpBnez:  taken = (a != 16'd0);
               OpBltz:  taken = a[15];
               default: taken = !a[15];
            endcase
            if (taken) begin
               expNextPc = mPc + 16'd2 + {{8{imm8[7]}}, imm8};
            end
         end
         OpJ:     expNextPc = mPc + 16'd2 + {{5{imm11[10]}}, imm11};
         OpHalt:  expHalt = 1'b1;
         OpNop:   ;
         default: expErr = 1'b1;                          // Err ignores valid
      endcase
      if (!expEn) begin
         expWb.en    = 1'b0;
         expReq.rdEn = 1'b0;
         expReq.wrEn = 1'b0;
      end
   endtask

   // Retire the previous cycle into the model
   task automatic commit();
      if (expEn) begin
         if (expWb.en) begin
            mRegs[expWb.regIdx] = expWb.data;
         end
         if (expReq.wrEn) begin
            mMem[expReq.addr[7:0]] = expReq.wdata;
         end
         mPc = expNextPc;
         if (expHalt) begin
            mHalted = 1'b1;
         end
      end
   endtask

   task automatic issue(input logic [15:0] word, input logic valid);
      @(posedge clk);
      #1;                                               // Drive after the edge
      commit();
      instr      = word;
      instrValid = valid;
      predict(word, valid);
   endtask

   task automatic endTest(input string name);
      issue(NopWord, 1'b0);                             // Write-back checks of the last word
      issue(NopWord, 1'b0);                             // Its pc and halted checks
      if (errCount == errAtStart) begin
         testsPassed++;
         $display("%s: ok", name);
      end else begin
         testsFailed++;
         $display("%s: %0d errors", name, errCount - errAtStart);
      end
      errAtStart = errCount;
   endtask

   task automatic checkReset();
      issue(NopWord, 1'b0);
      issue(NopWord, 1'b0);
      endTest("reset");
   endtask

   task automatic exerciseAlu();
      logic [31:0] r;
      for (int k = 0; k < 8; k++) begin
         r = $random(seed);
         issue({OpLbi, 3'(k), r[7:0]}, 1'b1);          // Seed every register
      end
      for (int k = 0; k < 4; k++) begin
         r = $random(seed);
         issue({OpSlbi, r[10:0]}, 1'b1);
      end
      for (int k = 0; k < AluOps; k++) begin
         r = $random(seed);
         if (r[31]) begin
            issue({OpAlu, r[10:0]}, 1'b1);
         end else begin
            issue({3'b010, r[12:11], r[10:0]}, 1'b1);   // ADDI to ANDNI
         end
      end
      endTest("alu");
   endtask

   task automatic storeAndLoad();
      logic [31:0] r;
      for (int k = 0; k < MemPairs; k++) begin
         r = $random(seed);
         issue({OpSt, r[10:0]}, 1'b1);
         issue({OpLd, r[10:8], r[13:11], r[4:0]}, 1'b1); // Reads back the store
         issue({OpLd, r[26:16]}, 1'b1);                  // Likely the fill pattern
      end
      endTest("load/store");
   endtask

   task automatic sweepBranches();
      logic [31:0] r;
      logic [7:0]  vals [3] = '{8'h00, 8'h05, 8'hFD};   // Zero, positive, negative
      for (int c = 0; c < 4; c++) begin
         for (int v = 0; v < 3; v++) begin
            r = $random(seed);
            issue({OpLbi, 3'd2, vals[v]}, 1'b1);
            issue({3'b011, 2'(c), 3'd2, r[7:1], 1'b0}, 1'b1);
         end
      end
      r = $random(seed);
      issue({OpJ, r[10:1], 1'b0}, 1'b1);
      issue({OpJ, 11'h7FE}, 1'b1);                       // Backward jump
      endTest("branch");
   endtask

   task automatic illegalOpcodes();
      logic [31:0] r;
      logic [4:0]  bad [4] = '{5'b00010, 5'b00110, 5'b10111, 5'b11111};
      for (int k = 0; k < 4; k++) begin
         r = $random(seed);
         issue({bad[k], r[10:0]}, 1'b1);
      end
      endTest("illegal");
   endtask

   task automatic idleThenHalt();
      logic [31:0] r;
      for (int k = 0; k < 4; k++) begin
         r = $random(seed);
         issue({OpAlu, r[10:0]}, 1'b0);                  // Live words, valid low
      end
      issue({OpHalt, 11'd0}, 1'b1);
      for (int k = 0; k < 6; k++) begin
         r = $random(seed);
         issue({OpAlu, r[10:0]}, 1'b1);                  // Ignored once halted
      end
      r = $random(seed);
      issue({OpSt, r[10:0]}, 1'b1);
      endTest("idle/halt");
   endtask

   initial begin
      rstN        = 1'b0;
      instr       = NopWord;
      instrValid  = 1'b0;
      mPc         = ResetPc;
      mHalted     = 1'b0;
      errCount    = 0;
      errAtStart  = 0;
      testsPassed = 0;
      testsFailed = 0;
      for (int a = 0; a < 256; a++) begin
         mem[a]  = 16'(a * 257) ^ 16'hA5C3;              // Both bytes follow the address
         mMem[a] = 16'(a * 257) ^ 16'hA5C3;
      end
      for (int k = 0; k < 8; k++) begin
         mRegs[k] = 16'd0;
      end
      predict(NopWord, 1'b0);
      repeat (4) @(posedge clk);
      #1;
      rstN = 1'b1;
      checkReset();
      exerciseAlu();
      storeAndLoad();
      sweepBranches();
      illegalOpcodes();
      idleThenHalt();
      $display("Summary: %0d tests ok, %0d tests with errors", testsPassed, testsFailed);
      if (testsFailed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WatchdogNs);
      $display("Timeout: run did not finish within %0d ns", WatchdogNs);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== design/wiscCore.sv ====
`timescale 1ns/1ps

module wiscCore import wiscPkg::*; #(
   parameter logic [DataWidth-1:0] ResetPc = '0
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  instrU                instr,
   input  logic                 instrValid,
   input  logic [DataWidth-1:0] memRdata,     // Same-cycle read data
   output memReqT               memReq,
   output wbT                   wb,           // Write-back trace
   output logic [DataWidth-1:0] pc,
   output logic                 halted,
   output logic                 err
);

   decodeOutT dec;
   execOutT   ex;
   logic      enable;

   decodeStage decode0 (
      .clk   (clk),
      .rstN  (rstN),
      .instr (instr),
      .wb    (wb),                                // Register write port
      .dec   (dec),
      .err   (err)
   );

   executeStage execute0 (
      .dec    (dec),
      .enable (enable),
      .ex     (ex),
      .memReq (memReq)
   );

   resultStage #(
      .ResetPc (ResetPc)
   ) result0 (
      .clk        (clk),
      .rstN       (rstN),
      .instrValid (instrValid),
      .ex         (ex),
      .memRdata   (memRdata),
      .wb         (wb),
      .pc         (pc),
      .halted     (halted),
      .enable     (enable)
   );

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/1ps

module resultStage import wiscPkg::*; #(
   parameter logic [DataWidth-1:0] ResetPc = '0
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 instrValid,
   input  execOutT              ex,
   input  logic [DataWidth-1:0] memRdata,
   output wbT                   wb,
   output logic [DataWidth-1:0] pc,
   output logic                 halted,
   output logic                 enable
);

   logic [DataWidth-1:0] pcInc;
   logic [DataWidth-1:0] pcNext;

   assign enable = instrValid & ~halted;          // Cycle is accepted

   assign wb.en     = enable & ex.ctrl.regWrite;
   assign wb.regIdx = ex.wrReg;
   assign wb.data   = ex.ctrl.memToReg ? memRdata : ex.aluRes;

   // Offset arrives as aluRes for branch and jump
   assign pcInc  = pc + DataWidth'(2);
   assign pcNext = (ex.brTaken | ex.ctrl.jump) ? pcInc + ex.aluRes : pcInc;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= ResetPc;
         halted <= 1'b0;
      end else if (enable) begin
         pc <= pcNext;                            // Illegal opcodes advance too
         if (ex.ctrl.halt) begin
            halted <= 1'b1;                       // Sticky until reset
         end
      end
   end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import wiscPkg::*; (
   input  decodeOutT dec,
   input  logic      enable,
   output execOutT   ex,
   output memReqT    memReq
);

   logic [DataWidth-1:0] opA;
   logic [DataWidth-1:0] opB;
   logic [DataWidth-1:0] aluRes;
   logic                 condMet;

   assign opA = dec.rdA;
   assign opB = dec.ctrl.aluSrcImm ? dec.imm : dec.rdB;

   always_comb begin
      case (dec.ctrl.aluOp)
         AluAdd:       aluRes = opA + opB;        // Also LD/ST address
         AluSub:       aluRes = opB - opA;        // WISC order
         AluXor:       aluRes = opA ^ opB;
         AluAndn:      aluRes = opA & ~opB;
         AluPassB:     aluRes = opB;              // LBI, branch and jump offsets
         AluShiftLoad: aluRes = {opA[DataWidth-9:0], 8'h00} | opB;
         default:      aluRes = '0;
      endcase
   end

   // Branch tests rs only
   always_comb begin
      case (dec.ctrl.brCond)
         BrEqz:   condMet = (dec.rdA == '0);
         BrNez:   condMet = (dec.rdA != '0);
         BrLtz:   condMet = dec.rdA[DataWidth-1];  // Sign set
         default: condMet = ~dec.rdA[DataWidth-1];
      endcase
   end

   assign memReq.rdEn  = enable & dec.ctrl.memRead;   // No strobes while idle or halted
   assign memReq.wrEn  = enable & dec.ctrl.memWrite;
   assign memReq.addr  = aluRes;
   assign memReq.wdata = dec.rdB;

   assign ex.aluRes  = aluRes;
   assign ex.brTaken = dec.ctrl.branch & condMet;
   assign ex.mem     = memReq;
   assign ex.ctrl    = dec.ctrl;
   assign ex.wrReg   = dec.wrReg;

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import wiscPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   input  instrU     instr,
   input  wbT        wb,
   output decodeOutT dec,
   output logic      err
);

   ctrlT                 ctrl;
   logic [DataWidth-1:0] rdA;
   logic [DataWidth-1:0] rdB;
   logic [DataWidth-1:0] imm;
   logic [2:0]           wrReg;
   logic [4:0]           imm5;
   logic [7:0]           imm8;
   logic [10:0]          imm11;

   controlDecoder ctrlDec0 (
      .opcode (instr.rFmt.opcode),
      .func   (instr.rFmt.func),
      .ctrl   (ctrl),
      .err    (err)
   );

   regFile regFile0 (
      .clk    (clk),
      .rstN   (rstN),
      .rdSelA (instr.rFmt.rs),
      .rdSelB (instr.rFmt.rt),                    // Also ST source (iFmt rd)
      .wb     (wb),
      .rdA    (rdA),
      .rdB    (rdB)
   );

   assign imm5  = instr.iFmt.imm5;
   assign imm8  = {instr.iFmt.rd, instr.iFmt.imm5};
   assign imm11 = {instr.iFmt.rs, instr.iFmt.rd, instr.iFmt.imm5};

   always_comb begin
      case (ctrl.immSel)
         ImmSel8:  imm = ctrl.zeroExt ? {{(DataWidth-8){1'b0}}, imm8}
                                      : {{(DataWidth-8){imm8[7]}}, imm8};
         ImmSel11: imm = {{(DataWidth-11){imm11[10]}}, imm11}; // J is always signed
         default:  imm = ctrl.zeroExt ? {{(DataWidth-5){1'b0}}, imm5}
                                      : {{(DataWidth-5){imm5[4]}}, imm5};
      endcase
   end

   always_comb begin
      case (ctrl.regDst)
         RegDstRs:  wrReg = instr.iFmt.rs;        // LBI, SLBI
         RegDstRdR: wrReg = instr.rFmt.rd;
         default:   wrReg = instr.iFmt.rd;
      endcase
   end

   assign dec = '{ctrl: ctrl, rdA: rdA, rdB: rdB, imm: imm, wrReg: wrReg};

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile import wiscPkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic [2:0]           rdSelA,
   input  logic [2:0]           rdSelB,
   input  wbT                   wb,
   output logic [DataWidth-1:0] rdA,
   output logic [DataWidth-1:0] rdB
);

   logic [DataWidth-1:0] regs [0:7];             // R0 is a normal register

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.en) begin
         regs[wb.regIdx] <= wb.data;
      end
   end

   // No write bypass, new value shows next cycle
   assign rdA = regs[rdSelA];
   assign rdB = regs[rdSelB];

endmodule

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder import wiscPkg::*; (
   input  opcodeE     opcode,
   input  logic [1:0] func,
   output ctrlT       ctrl,
   output logic       err
);

   always_comb begin
      ctrl = '0;                                  // NOP and illegal share this
      err  = 1'b0;
      case (opcode)
         OpHalt: ctrl.halt = 1'b1;
         OpNop: ;                                 // Nothing to do
         OpAlu: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = RegDstRdR;
            case (func)                           // Func selects the operation
               2'b00:   ctrl.aluOp = AluAdd;
               2'b01:   ctrl.aluOp = AluSub;
               2'b10:   ctrl.aluOp = AluXor;
               default: ctrl.aluOp = AluAndn;
            endcase
         end
         OpAddi, OpSubi, OpXori, OpAndni: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDst    = RegDstRdI;
            ctrl.immSel    = ImmSel5;
            ctrl.aluSrcImm = 1'b1;
            ctrl.zeroExt   = opcode inside {OpXori, OpAndni}; // Logical ops zero-extend
            case (opcode)
               OpAddi:  ctrl.aluOp = AluAdd;
               OpSubi:  ctrl.aluOp = AluSub;
               OpXori:  ctrl.aluOp = AluXor;
               default: ctrl.aluOp = AluAndn;
            endcase
         end
         OpLbi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDst    = RegDstRs;            // LBI writes rs
            ctrl.immSel    = ImmSel8;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = AluPassB;
         end
         OpSlbi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDst    = RegDstRs;
            ctrl.immSel    = ImmSel8;
            ctrl.zeroExt   = 1'b1;                // Low byte is or-ed in unsigned
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = AluShiftLoad;
         end
         OpSt, OpLd: begin
            ctrl.immSel    = ImmSel5;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = AluAdd;              // Address = rs + imm5
            ctrl.memWrite  = (opcode == OpSt);
            ctrl.memRead   = (opcode == OpLd);
            ctrl.memToReg  = (opcode == OpLd);
            ctrl.regWrite  = (opcode == OpLd);
            ctrl.regDst    = RegDstRdI;
         end
         OpBeqz, OpBnez, OpBltz, OpBgez: begin
            ctrl.branch    = 1'b1;
            ctrl.brCond    = opcode[1:0];         // Low opcode bits match brCond codes
            ctrl.immSel    = ImmSel8;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = AluPassB;            // Offset rides out on aluRes
         end
         OpJ: begin
            ctrl.jump      = 1'b1;
            ctrl.immSel    = ImmSel11;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = AluPassB;
         end
         default: err = 1'b1;                     // Unsupported opcode
      endcase
   end

endmodule

// ==== design/wiscPkg.sv ====
package wiscPkg;

   localparam int DataWidth = 16;                 // Machine word size

   typedef enum logic [4:0] {
      OpHalt  = 5'b00000,
      OpNop   = 5'b00001,
      OpJ     = 5'b00100,
      OpAddi  = 5'b01000,
      OpSubi  = 5'b01001,
      OpXori  = 5'b01010,
      OpAndni = 5'b01011,
      OpBeqz  = 5'b01100,
      OpBnez  = 5'b01101,
      OpBltz  = 5'b01110,
      OpBgez  = 5'b01111,
      OpSt    = 5'b10000,
      OpLd    = 5'b10001,
      OpSlbi  = 5'b10010,
      OpLbi   = 5'b11000,
      OpAlu   = 5'b11011                          // ADD/SUB/XOR/ANDN, func picks
   } opcodeE;

   typedef enum logic [2:0] {
      AluAdd       = 3'd0,
      AluSub       = 3'd1,                        // B minus A
      AluXor       = 3'd2,
      AluAndn      = 3'd3,                        // A and not B
      AluPassB     = 3'd4,
      AluShiftLoad = 3'd5                         // SLBI
   } aluOpE;

   // regDst codes
   localparam logic [1:0] RegDstRdI = 2'd0;      // rd of iFmt
   localparam logic [1:0] RegDstRs  = 2'd1;
   localparam logic [1:0] RegDstRdR = 2'd2;      // rd of rFmt

   // immSel codes
   localparam logic [1:0] ImmSel5  = 2'd0;
   localparam logic [1:0] ImmSel8  = 2'd1;
   localparam logic [1:0] ImmSel11 = 2'd2;

   // brCond codes
   localparam logic [1:0] BrEqz = 2'd0;
   localparam logic [1:0] BrNez = 2'd1;
   localparam logic [1:0] BrLtz = 2'd2;
   localparam logic [1:0] BrGez = 2'd3;

   typedef struct packed {
      opcodeE     opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } rFmtT;

   typedef struct packed {
      opcodeE     opcode;
      logic [2:0] rs;
      logic [2:0] rd;                             // Same bits as rt
      logic [4:0] imm5;
   } iFmtT;

   typedef union packed {
      rFmtT rFmt;
      iFmtT iFmt;
   } instrU;

   typedef struct packed {
      logic       regWrite;
      logic [1:0] regDst;
      logic       zeroExt;
      logic [1:0] immSel;
      logic       aluSrcImm;
      aluOpE      aluOp;
      logic       memRead;
      logic       memWrite;
      logic       memToReg;
      logic       branch;
      logic [1:0] brCond;
      logic       jump;
      logic       halt;
   } ctrlT;

   typedef struct packed {
      ctrlT                 ctrl;
      logic [DataWidth-1:0] rdA;
      logic [DataWidth-1:0] rdB;
      logic [DataWidth-1:0] imm;
      logic [2:0]           wrReg;
   } decodeOutT;

   typedef struct packed {
      logic                 rdEn;
      logic                 wrEn;
      logic [DataWidth-1:0] addr;
      logic [DataWidth-1:0] wdata;
   } memReqT;

   typedef struct packed {
      logic [DataWidth-1:0] aluRes;
      logic                 brTaken;
      memReqT               mem;
      ctrlT                 ctrl;
      logic [2:0]           wrReg;
   } execOutT;

   typedef struct packed {
      logic                 en;
      logic [2:0]           regIdx;               // Destination register
      logic [DataWidth-1:0] data;
   } wbT;

endpackage
